// File: sources.f
hw/bus_pkg.sv
hw/display_pkg.sv
hw/bus_bridge.sv
hw/segment_display.sv
hw/led_port.sv
hw/periph_top.sv
verification/periph_chk.sv
verification/periph_tb.sv

// File: Makefile
# Verilator flow for the peripheral subsystem

VERILATOR  = verilator
TOP        = periph_tb
FILELIST   = sources.f
BUILD_DIR  = obj_dir
LOG        = sim.log
LINT_FLAGS = --lint-only --timing
SIM_FLAGS  = --binary --timing --assert -j 0
FAIL_MSG   = Done: errors found
PASS_MSG   = Done: no errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED: run did not complete"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/periph_tb.sv
`timescale 1ns/1ps
`default_nettype none

module periph_tb;
    import bus_pkg::*;
    import display_pkg::*;

    localparam int          ACK_TIMEOUT = 20;
    localparam logic [31:0] RANDOM_SEED = 32'h6187;

    localparam logic [ADDR_W-1:0] DSP_CTRL_ADDR = {DEV_DISPLAY, PORT_DSP_CONTROL};
    localparam logic [ADDR_W-1:0] DSP_DATA_ADDR = {DEV_DISPLAY, PORT_DSP_DATA};
    localparam logic [ADDR_W-1:0] LED_OUT_ADDR  = {DEV_LEDS, PORT_LED_OUT};
    localparam logic [ADDR_W-1:0] LED_SW_ADDR   = {DEV_LEDS, PORT_LED_SW};

    // What a table row compares after its transfer
    localparam logic [1:0] CHECK_NONE = 2'd0;
    localparam logic [1:0] CHECK_READ = 2'd1;
    localparam logic [1:0] CHECK_LEDS = 2'd2;

    typedef struct packed {
        logic              we;
        logic [ADDR_W-1:0] addr;
        word_t             data;
        logic [3:0]        mask;
        logic [1:0]        check;
        word_t             expected;
    } row_t;

    logic              clk_i;
    logic              rst_n_i;
    logic              req;
    logic              we;
    logic [ADDR_W-1:0] addr;
    word_t             wdata;
    logic [3:0]        wmask;
    logic              ack;
    word_t             rdata;
    logic [7:0]        anode;
    logic [7:0]        cathode;
    logic [15:0]       leds;
    logic [15:0]       sw;

    row_t              rows_q[$];
    string             names_q[$];
    digit_word_u       shown;

    periph_top #(
        .CLK_DIVISOR      (4),
        .DSP_INIT_ENABLED (1'b0),
        .DSP_INIT_VALUE   (32'h0)
    ) dut_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req),
        .we_i          (we),
        .addr_i        (addr),
        .wdata_i       (wdata),
        .wmask_i       (wmask),
        .ack_o         (ack),
        .rdata_o       (rdata),
        .dsp_anode_o   (anode),
        .dsp_cathode_o (cathode),
        .leds_o        (leds),
        .sw_i          (sw)
    );

    bind periph_top periph_chk chk_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .ack_i     (ack_o),
        .anode_i   (dsp_anode_o),
        .cathode_i (dsp_cathode_o)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic compare_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic add_row(input string name, input logic we_bit,
                           input logic [ADDR_W-1:0] address, input word_t data,
                           input logic [3:0] mask, input logic [1:0] check,
                           input word_t expected);
        row_t row;
        row.we       = we_bit;
        row.addr     = address;
        row.data     = data;
        row.mask     = mask;
        row.check    = check;
        row.expected = expected;
        rows_q.push_back(row);
        names_q.push_back(name);
    endtask

    task automatic build_table();
        add_row("dsp_ctrl_reset", 1'b0, DSP_CTRL_ADDR, '0, 4'h0, CHECK_READ, '0);
        add_row("dsp_data_reset", 1'b0, DSP_DATA_ADDR, '0, 4'h0, CHECK_READ, '0);
        add_row("dsp_data_full", 1'b1, DSP_DATA_ADDR, 32'h7654_3210, 4'hF, CHECK_NONE, '0);
        add_row("dsp_data_full_rd", 1'b0, DSP_DATA_ADDR, '0, 4'h0, CHECK_READ, 32'h7654_3210);
        add_row("dsp_data_b1", 1'b1, DSP_DATA_ADDR, 32'hA5A5_A5A5, 4'b0010, CHECK_NONE, '0);
        add_row("dsp_data_b1_rd", 1'b0, DSP_DATA_ADDR, '0, 4'h0, CHECK_READ, 32'h7654_A510);
        add_row("dsp_data_b30", 1'b1, DSP_DATA_ADDR, 32'hFEDC_BA98, 4'b1001, CHECK_NONE, '0);
        add_row("dsp_data_b30_rd", 1'b0, DSP_DATA_ADDR, '0, 4'h0, CHECK_READ, 32'hFE54_A598);
        add_row("led_full", 1'b1, LED_OUT_ADDR, 32'hDEAD_BEEF, 4'hF, CHECK_LEDS, 32'hBEEF);
        add_row("led_full_rd", 1'b0, LED_OUT_ADDR, '0, 4'h0, CHECK_READ, 32'hBEEF);
        add_row("led_b1", 1'b1, LED_OUT_ADDR, 32'h1234_5678, 4'b0010, CHECK_LEDS, 32'h56EF);
        add_row("led_b1_rd", 1'b0, LED_OUT_ADDR, '0, 4'h0, CHECK_READ, 32'h56EF);
        // Upper bytes have no LED bits behind them
        add_row("led_upper", 1'b1, LED_OUT_ADDR, 32'hFFFF_0011, 4'b1100, CHECK_LEDS, 32'h56EF);
        add_row("led_sw_write", 1'b1, LED_SW_ADDR, 32'hFFFF_FFFF, 4'hF, CHECK_LEDS, 32'h56EF);
        add_row("unmapped_write", 1'b1, 8'h21, 32'hFFFF_FFFF, 4'hF, CHECK_NONE, '0);
        add_row("unmapped_read", 1'b0, 8'h21, '0, 4'h0, CHECK_READ, '0);
        add_row("dsp_unused_rd", 1'b0, {DEV_DISPLAY, 4'h7}, '0, 4'h0, CHECK_READ, '0);
        add_row("led_unused_rd", 1'b0, {DEV_LEDS, 4'hF}, '0, 4'h0, CHECK_READ, '0);
        add_row("dsp_data_kept", 1'b0, DSP_DATA_ADDR, '0, 4'h0, CHECK_READ, 32'hFE54_A598);
        add_row("led_kept", 1'b0, LED_OUT_ADDR, '0, 4'h0, CHECK_READ, 32'h56EF);
    endtask

    // One four-phase transfer with req optionally held past the ack
    task automatic run_transfer(input string name, input logic we_bit,
                                input logic [ADDR_W-1:0] address, input word_t data,
                                input logic [3:0] mask, input int hold_cycles,
                                output word_t read_word);
        int waited;
        assert (ack == 1'b0) else begin
            $display("Test %s: ack still high before the request", name);
            abort_run();
        end
        @(posedge clk_i);
        req   <= 1'b1;
        we    <= we_bit;
        addr  <= address;
        wdata <= data;
        wmask <= mask;
        waited = 0;
        while (ack !== 1'b1) begin
            assert (waited < ACK_TIMEOUT) else begin
                $display("Test %s: no ack within %0d cycles", name, ACK_TIMEOUT);
                abort_run();
            end
            @(negedge clk_i);
            waited++;
        end
        read_word = rdata;
        for (int h = 0; h < hold_cycles; h++) begin
            @(posedge clk_i);
            wdata <= ~data;
            @(negedge clk_i);
            assert (ack == 1'b1) else begin
                $display("Test %s: ack dropped while req was held", name);
                abort_run();
            end
        end
        @(posedge clk_i);
        req <= 1'b0;
        we  <= 1'b0;
        waited = 0;
        while (ack !== 1'b0) begin
            assert (waited < ACK_TIMEOUT) else begin
                $display("Test %s: ack stuck high after req dropped", name);
                abort_run();
            end
            @(negedge clk_i);
            waited++;
        end
    endtask

    // Sample the display pins at the falling edge
    task automatic check_scan(input string name, input int cycles, input bit expect_scan);
        logic [7:0] low;
        logic [7:0] seen;
        logic [7:0] expected;
        seen = '0;
        for (int c = 0; c < cycles; c++) begin
            @(negedge clk_i);
            low = ~anode;
            assert ($countones(low) <= 1) else begin
                $display("Test %s: several anodes low at once (%b)", name, anode);
                abort_run();
            end
            expected = 8'hFF;
            for (int d = 0; d < 8; d++) begin
                if (low[d]) begin
                    seen[d]  = 1'b1;
                    expected = SEG_PATTERNS[shown.nibble[d]];
                end
            end
            assert (cathode === expected) else begin
                $display("MISMATCH %s: expected %h, actual %h", name, expected, cathode);
                abort_run();
            end
        end
        if (expect_scan) begin
            assert (seen == 8'hFF) else begin
                $display("Test %s: digits %b were never shown", name, ~seen);
                abort_run();
            end
        end else begin
            assert (seen == 8'h00) else begin
                $display("Test %s: a digit was lit while the display was off", name);
                abort_run();
            end
        end
    endtask

    initial begin
        row_t        row;
        word_t       read_word;
        logic [31:0] rnd;
        clk_i   = 1'b0;
        rst_n_i = 1'b0;
        req     = 1'b0;
        we      = 1'b0;
        addr    = '0;
        wdata   = '0;
        wmask   = '0;
        sw      = '0;
        rnd     = RANDOM_SEED;
        shown.raw = 32'h0;
        build_table();

        repeat (3) @(posedge clk_i);
        rst_n_i <= 1'b1;

        check_scan("display_off", 16, 1'b0);

        for (int i = 0; i < rows_q.size(); i++) begin
            row = rows_q[i];
            run_transfer(names_q[i], row.we, row.addr, row.data, row.mask, 0, read_word);
            if (row.check == CHECK_READ) begin
                compare_word(names_q[i], row.expected, read_word);
            end else if (row.check == CHECK_LEDS) begin
                compare_word(names_q[i], row.expected, {16'b0, leds});
            end
        end

        // Switches settle through the synchronizer before the read
        for (int k = 0; k < 3; k++) begin
            rnd = next_random(rnd);
            @(posedge clk_i);
            sw <= rnd[15:0];
            repeat (4) @(posedge clk_i);
            run_transfer("switch_read", 1'b0, LED_SW_ADDR, '0, 4'h0, 0, read_word);
            compare_word($sformatf("switch_read_%0d", k), {16'b0, rnd[15:0]}, read_word);
        end

        run_transfer("held_write", 1'b1, DSP_DATA_ADDR, 32'h0123_4567, 4'hF, 5, read_word);
        run_transfer("held_read", 1'b0, DSP_DATA_ADDR, '0, 4'h0, 0, read_word);
        compare_word("held_read", 32'h0123_4567, read_word);
        shown.raw = 32'h0123_4567;

        run_transfer("enable", 1'b1, DSP_CTRL_ADDR, 32'h1, 4'b0001, 0, read_word);
        run_transfer("enable_rd", 1'b0, DSP_CTRL_ADDR, '0, 4'h0, 0, read_word);
        compare_word("enable_rd", 32'h1, read_word);

        // Two and a half scan periods of 64 cycles
        check_scan("display_scan", 160, 1'b1);

        if (dut_i.chk_i.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times", dut_i.chk_i.fail_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: verification/periph_chk.sv
`timescale 1ns/1ps
`default_nettype none

module periph_chk (
    input wire logic       clk_i,
    input wire logic       rst_n_i,
    input wire logic       req_i,
    input wire logic       ack_i,
    input wire logic [7:0] anode_i,
    input wire logic [7:0] cathode_i
);

    // Count of failed assertions
    int unsigned fail_count;

    initial begin
        fail_count = 0;
    end

    // ack may only come up for a pending request
    ack_needs_req: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_i) |-> req_i
    ) else begin
        $error("ack rose while req was low");
        fail_count++;
    end

    // Multiplexed display lights one digit at a time
    one_anode_low: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        $countones(~anode_i) <= 1
    ) else begin
        $error("more than one anode driven low");
        fail_count++;
    end

    dark_after_reset: assert property (
        @(posedge clk_i)
        $rose(rst_n_i) |-> (anode_i == 8'hFF && cathode_i == 8'hFF)
    ) else begin
        $error("display not dark in the cycle after reset");
        fail_count++;
    end

endmodule

`default_nettype wire

// File: hw/periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
    parameter int unsigned    CLK_DIVISOR      = 32768,
    parameter bit             DSP_INIT_ENABLED = 1'b0,
    parameter bus_pkg::word_t DSP_INIT_VALUE   = '0
) (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,

    // Host port
    input  wire logic                       req_i,
    input  wire logic                       we_i,
    input  wire logic [bus_pkg::ADDR_W-1:0] addr_i,
    input  wire bus_pkg::word_t             wdata_i,
    input  wire logic [3:0]                 wmask_i,
    output wire logic                       ack_o,
    output wire bus_pkg::word_t             rdata_o,

    // Board pins
    output wire logic [7:0]                 dsp_anode_o,
    output wire logic [7:0]                 dsp_cathode_o,
    output wire logic [15:0]                leds_o,
    input  wire logic [15:0]                sw_i
);
    import bus_pkg::*;

    // Shared peripheral bus
    logic [PORT_W-1:0] port_addr;
    logic              read_enable;
    word_t             write_data;
    logic [3:0]        write_mask;

    logic              dsp_select;
    word_t             dsp_read_data;
    logic              led_select;
    word_t             led_read_data;

    bus_bridge bridge_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .req_i           (req_i),
        .we_i            (we_i),
        .addr_i          (addr_i),
        .wdata_i         (wdata_i),
        .wmask_i         (wmask_i),
        .ack_o           (ack_o),
        .rdata_o         (rdata_o),
        .port_addr_o     (port_addr),
        .read_enable_o   (read_enable),
        .write_data_o    (write_data),
        .write_mask_o    (write_mask),
        .dsp_select_o    (dsp_select),
        .dsp_read_data_i (dsp_read_data),
        .led_select_o    (led_select),
        .led_read_data_i (led_read_data)
    );

    segment_display #(
        .CLK_DIVISOR  (CLK_DIVISOR),
        .INIT_ENABLED (DSP_INIT_ENABLED),
        .INIT_VALUE   (DSP_INIT_VALUE)
    ) display_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dsp_anode_o   (dsp_anode_o),
        .dsp_cathode_o (dsp_cathode_o),
        .chip_select_i (dsp_select),
        .addr_i        (port_addr),
        .read_enable_i (read_enable),
        .read_data_o   (dsp_read_data),
        .write_data_i  (write_data),
        .write_mask_i  (write_mask)
    );

    led_port leds_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .chip_select_i (led_select),
        .addr_i        (port_addr),
        .read_enable_i (read_enable),
        .read_data_o   (led_read_data),
        .write_data_i  (write_data),
        .write_mask_i  (write_mask),
        .leds_o        (leds_o),
        .sw_i          (sw_i)
    );

endmodule

`default_nettype wire

// File: hw/led_port.sv
`timescale 1ns/1ps
`default_nettype none

module led_port (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,

    // Peripheral bus
    input  wire logic                       chip_select_i,
    input  wire logic [bus_pkg::PORT_W-1:0] addr_i,
    input  wire logic                       read_enable_i,
    output wire bus_pkg::word_t             read_data_o,
    input  wire bus_pkg::word_t             write_data_i,
    input  wire logic [3:0]                 write_mask_i,

    // Board pins
    output wire logic [15:0]                leds_o,
    input  wire logic [15:0]                sw_i
);
    import bus_pkg::*;

    logic [15:0] leds_r;
    logic [15:0] sw_meta_r;
    logic [15:0] sw_sync_r;
    word_t       read_data_r;

    // LED register, low two bytes only
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            leds_r <= '0;
        end else if (chip_select_i && addr_i == PORT_LED_OUT) begin
            if (write_mask_i[0]) begin
                leds_r[7:0] <= write_data_i[7:0];
            end
            if (write_mask_i[1]) begin
                leds_r[15:8] <= write_data_i[15:8];
            end
        end
    end

    // Switches are asynchronous to clk_i
    always_ff @(posedge clk_i) begin
        sw_meta_r <= sw_i;
        sw_sync_r <= sw_meta_r;
    end

    always_ff @(posedge clk_i) begin
        if (chip_select_i && read_enable_i) begin
            case (addr_i)
                PORT_LED_OUT: read_data_r <= {16'b0, leds_r};
                PORT_LED_SW:  read_data_r <= {16'b0, sw_sync_r};
                default:      read_data_r <= '0;
            endcase
        end
    end

    assign read_data_o = read_data_r;
    assign leds_o      = leds_r;

endmodule

`default_nettype wire

// File: hw/segment_display.sv
`timescale 1ns/1ps
`default_nettype none

module segment_display #(
    parameter int unsigned    CLK_DIVISOR  = 32768,
    parameter bit             INIT_ENABLED = 1'b0,
    parameter bus_pkg::word_t INIT_VALUE   = '0
) (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,

    // Active-low display pins
    output wire logic [7:0]                 dsp_anode_o,
    output wire logic [7:0]                 dsp_cathode_o,

    // Peripheral bus
    input  wire logic                       chip_select_i,
    input  wire logic [bus_pkg::PORT_W-1:0] addr_i,
    input  wire logic                       read_enable_i,
    output wire bus_pkg::word_t             read_data_o,
    input  wire bus_pkg::word_t             write_data_i,
    input  wire logic [3:0]                 write_mask_i
);
    import bus_pkg::*;
    import display_pkg::*;

    // Low bits divide the clock and the top four pick digit and half slot
    localparam int unsigned COUNTER_W = $clog2(CLK_DIVISOR) + 4;

    logic                 enabled_r;
    digit_word_u          value_r;
    word_t                read_data_r;

    logic [COUNTER_W-1:0] counter_r;
    logic [2:0]           digit;
    logic                 slot_on;
    logic [3:0]           nibble;

    logic [7:0]           anode_r;
    logic [7:0]           cathode_r;

    // Register writes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            enabled_r   <= INIT_ENABLED;
            value_r.raw <= INIT_VALUE;
        end else if (chip_select_i) begin
            case (addr_i)
                PORT_DSP_CONTROL: begin
                    if (write_mask_i[0]) begin
                        enabled_r <= write_data_i[0];
                    end
                end
                PORT_DSP_DATA: begin
                    for (int b = 0; b < 4; b++) begin
                        if (write_mask_i[b]) begin
                            value_r.raw[8*b +: 8] <= write_data_i[8*b +: 8];
                        end
                    end
                end
                default: ;
            endcase
        end
    end

    // Register reads
    always_ff @(posedge clk_i) begin
        if (chip_select_i && read_enable_i) begin
            case (addr_i)
                PORT_DSP_CONTROL: read_data_r <= {31'b0, enabled_r};
                PORT_DSP_DATA:    read_data_r <= value_r.raw;
                default:          read_data_r <= '0;
            endcase
        end
    end

    assign read_data_o = read_data_r;

    // Scan counter held at zero while disabled
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            counter_r <= '0;
        end else if (enabled_r) begin
            counter_r <= counter_r + COUNTER_W'(1);
        end else begin
            counter_r <= '0;
        end
    end

    always_comb begin
        {digit, slot_on} = counter_r[COUNTER_W-1 -: 4];
        nibble           = value_r.nibble[digit];
    end

    // Anode select
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            anode_r <= 8'hFF;
        end else begin
            anode_r <= 8'hFF;
            if (slot_on) begin
                anode_r[digit] <= 1'b0;
            end
        end
    end

    // Segment pattern for the active digit
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            cathode_r <= 8'hFF;
        end else if (slot_on) begin
            cathode_r <= SEG_PATTERNS[nibble];
        end else begin
            cathode_r <= 8'hFF;
        end
    end

    assign dsp_anode_o   = anode_r;
    assign dsp_cathode_o = cathode_r;

endmodule

`default_nettype wire

// File: hw/bus_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module bus_bridge (
    input  wire logic                       clk_i,
    input  wire logic                       rst_n_i,

    // Host side, four-phase handshake
    input  wire logic                       req_i,
    input  wire logic                       we_i,
    input  wire logic [bus_pkg::ADDR_W-1:0] addr_i,
    input  wire bus_pkg::word_t             wdata_i,
    input  wire logic [3:0]                 wmask_i,
    output wire logic                       ack_o,
    output wire bus_pkg::word_t             rdata_o,

    // Peripheral side
    output wire logic [bus_pkg::PORT_W-1:0] port_addr_o,
    output wire logic                       read_enable_o,
    output wire bus_pkg::word_t             write_data_o,
    output wire logic [3:0]                 write_mask_o,
    output wire logic                       dsp_select_o,
    input  wire bus_pkg::word_t             dsp_read_data_i,
    output wire logic                       led_select_o,
    input  wire bus_pkg::word_t             led_read_data_i
);
    import bus_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        STROBE,
        WAIT_DATA,
        ACK
    } state_t;

    state_t            state_r;
    dev_t              dev_r;
    logic              dsp_select_r;
    logic              led_select_r;
    logic              ack_r;
    logic [PORT_W-1:0] port_addr_r;
    logic              read_enable_r;
    word_t             write_data_r;
    logic [3:0]        write_mask_r;
    word_t             rdata;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_r      <= IDLE;
            dsp_select_r <= 1'b0;
            led_select_r <= 1'b0;
            ack_r        <= 1'b0;
        end else begin
            // Selects are single-cycle strobes
            dsp_select_r <= 1'b0;
            led_select_r <= 1'b0;
            unique case (state_r)
                IDLE: begin
                    if (req_i) begin
                        state_r <= STROBE;
                    end
                end
                STROBE: begin
                    dsp_select_r <= (dev_r == DEV_DISPLAY);
                    led_select_r <= (dev_r == DEV_LEDS);
                    state_r      <= WAIT_DATA;
                end
                WAIT_DATA: begin
                    // Peripheral registers its read word on this same edge
                    ack_r   <= 1'b1;
                    state_r <= ACK;
                end
                ACK: begin
                    if (!req_i) begin
                        ack_r   <= 1'b0;
                        state_r <= IDLE;
                    end
                end
                default: state_r <= IDLE;
            endcase
        end
    end

    // Request fields, latched when the transfer is accepted
    always_ff @(posedge clk_i) begin
        if (state_r == IDLE && req_i) begin
            dev_r         <= dev_t'(addr_i[ADDR_W-1 -: DEV_W]);
            port_addr_r   <= addr_i[PORT_W-1:0];
            read_enable_r <= !we_i;
            write_data_r  <= wdata_i;
            write_mask_r  <= we_i ? wmask_i : 4'b0000;
        end
    end

    // Unmapped devices read as zero
    always_comb begin
        case (dev_r)
            DEV_DISPLAY: rdata = dsp_read_data_i;
            DEV_LEDS:    rdata = led_read_data_i;
            default:     rdata = '0;
        endcase
    end

    assign ack_o         = ack_r;
    assign rdata_o       = rdata;
    assign port_addr_o   = port_addr_r;
    assign read_enable_o = read_enable_r;
    assign write_data_o  = write_data_r;
    assign write_mask_o  = write_mask_r;
    assign dsp_select_o  = dsp_select_r;
    assign led_select_o  = led_select_r;

endmodule

`default_nettype wire

// File: hw/display_pkg.sv
`default_nettype none

package display_pkg;

    localparam int unsigned NUM_DIGITS = 8;

    // Display value, as a bus word or as one nibble per digit
    // Nibble 0 is the rightmost digit
    typedef union packed {
        bus_pkg::word_t                  raw;
        logic [NUM_DIGITS-1:0][3:0]      nibble;
    } digit_word_u;

    // Active-low cathodes, bit 7 is the decimal point (kept dark)
    // Bits 6..0 map to segments g..a
    localparam logic [7:0] SEG_PATTERNS [0:15] = '{
        8'b1100_0000,
        8'b1111_1001,
        8'b1010_0100,
        8'b1011_0000,
        8'b1001_1001,
        8'b1001_0010,
        8'b1000_0010,
        8'b1111_1000,
        8'b1000_0000,
        8'b1001_1000,
        // Letters A to F
        8'b1000_1000,
        8'b1000_0011,
        8'b1100_0110,
        8'b1010_0001,
        8'b1000_0110,
        8'b1000_1110
    };

endpackage

`default_nettype wire

// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // Data word of the host port and the peripheral bus
    typedef logic [31:0] word_t;

    // Host address is a device nibble over a register port nibble
    localparam int unsigned DEV_W  = 4;
    localparam int unsigned PORT_W = 4;
    localparam int unsigned ADDR_W = DEV_W + PORT_W;

    typedef enum logic [DEV_W-1:0] {
        DEV_DISPLAY = 4'd0,
        DEV_LEDS    = 4'd1
    } dev_t;

    // Seven-segment display registers
    localparam logic [PORT_W-1:0] PORT_DSP_CONTROL = 4'd0;
    localparam logic [PORT_W-1:0] PORT_DSP_DATA    = 4'd1;

    // LED and switch registers
    localparam logic [PORT_W-1:0] PORT_LED_OUT = 4'd0;
    localparam logic [PORT_W-1:0] PORT_LED_SW  = 4'd1;

endpackage

`default_nettype wire
